/* hw/mem_cfg_pkg.sv */
// memory path configuration
// sizes, depths and latency constants shared by the memory response path,
// plus the state encoding of the drop unit

`default_nettype none

package mem_cfg_pkg;

  //==========================================================================
  // memory
  //==========================================================================

  // number of words in the test memory
  localparam int mem_words = 64;

  // pipeline stages between request accept and response output
  localparam int mem_latency = 2;

  //==========================================================================
  // response queue
  //==========================================================================

  // entries held by the response queue
  localparam int resp_queue_depth = 2;

  // pointer and occupancy widths derived from the depth
  localparam int resp_queue_ptr_bits = (resp_queue_depth > 1) ? $clog2(resp_queue_depth) : 1;
  localparam int resp_queue_cnt_bits = $clog2(resp_queue_depth + 1);

  //==========================================================================
  // drop unit
  //==========================================================================

  // pass forwards responses, drop discards the next arriving one
  typedef enum logic {
    state_pass = 1'b0,
    state_drop = 1'b1
  } drop_state_t;

endpackage

`default_nettype wire

/* hw/mem_msg_pkg.sv */
// memory message formats
// field widths and typedefs of the request and response messages seen by
// the memory, the response queue and the drop unit

`default_nettype none

package mem_msg_pkg;

  //==========================================================================
  // field widths
  //==========================================================================

  localparam int mem_addr_bits = 6;
  localparam int mem_data_bits = 32;

  // opaque tag, set by the requester and echoed in the response
  localparam int mem_tag_bits = 4;

  // response is type + tag + data
  localparam int mem_resp_bits = 1 + mem_tag_bits + mem_data_bits;

  //==========================================================================
  // field types
  //==========================================================================

  // word address
  typedef logic [mem_addr_bits-1:0] mem_addr_t;

  // data word
  typedef logic [mem_data_bits-1:0] mem_data_t;

  // request tag
  typedef logic [mem_tag_bits-1:0] mem_tag_t;

  // request and response type
  typedef enum logic {
    mem_read  = 1'b0,
    mem_write = 1'b1
  } mem_type_t;

  //==========================================================================
  // response message
  //==========================================================================

  // packed as {type, tag, data}, msb first
  // queue and drop unit never look inside
  typedef logic [mem_resp_bits-1:0] mem_resp_t;

endpackage

`default_nettype wire

/* hw/test_mem.sv */
// test memory
// pipelined word memory with valid/ready on both sides. a request is
// written or read in its accept cycle and the result travels through
// mem_latency stage registers to the response port. a stalled output
// stage backs up the pipeline and finally drops req_rdy.

`timescale 1ns/1ps
`default_nettype none

module test_mem (
  input  logic                   clk,
  input  logic                   reset,

  // request side
  input  mem_msg_pkg::mem_type_t req_type,
  input  mem_msg_pkg::mem_tag_t  req_tag,
  input  mem_msg_pkg::mem_addr_t req_addr,
  input  mem_msg_pkg::mem_data_t req_data,
  input  logic                   req_val,
  output logic                   req_rdy,

  // response side
  output mem_msg_pkg::mem_resp_t resp_msg,
  output logic                   resp_val,
  input  logic                   resp_rdy
);

  import mem_cfg_pkg::*;
  import mem_msg_pkg::*;

  //==========================================================================
  // storage and pipeline state
  //==========================================================================

  // word array, no reset
  mem_data_t mem [mem_words];

  // stage 0 is loaded in the accept cycle, last stage drives the output
  logic      stage_val  [mem_latency];
  mem_resp_t stage_msg  [mem_latency];

  // a stage can take new content this cycle
  logic      stage_free [mem_latency];

  logic      req_go;
  mem_data_t rd_data;

  //==========================================================================
  // flow control
  //==========================================================================

  // last stage frees up when empty or when the consumer takes it
  // earlier stages free up when empty or when the next one moves
  always_comb begin
    stage_free[mem_latency-1] = !stage_val[mem_latency-1] || resp_rdy;
    for (int i = mem_latency - 2; i >= 0; i--) begin
      stage_free[i] = !stage_val[i] || stage_free[i+1];
    end
  end

  assign req_rdy = stage_free[0];
  assign req_go  = req_val && req_rdy;

  //==========================================================================
  // memory access
  //==========================================================================

  // writes commit on the accept edge, so a read accepted on the next edge
  // already sees the new value
  always_ff @(posedge clk) begin
    if (req_go && req_type == mem_write) begin
      mem[req_addr] <= req_data;
    end
  end

  // read data for reads, write responses echo the written word
  assign rd_data = (req_type == mem_write) ? req_data : mem[req_addr];

  //==========================================================================
  // pipeline
  //==========================================================================

  // valid bits
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < mem_latency; i++) begin
        stage_val[i] <= 1'b0;
      end
    end else begin
      if (stage_free[0]) begin
        stage_val[0] <= req_val;
      end
      for (int i = 1; i < mem_latency; i++) begin
        if (stage_free[i]) begin
          stage_val[i] <= stage_val[i-1];
        end
      end
    end
  end

  // payload moves along with the valid bits
  always_ff @(posedge clk) begin
    if (stage_free[0]) begin
      stage_msg[0] <= {req_type, req_tag, rd_data};
    end
    for (int i = 1; i < mem_latency; i++) begin
      if (stage_free[i]) begin
        stage_msg[i] <= stage_msg[i-1];
      end
    end
  end

  assign resp_msg = stage_msg[mem_latency-1];
  assign resp_val = stage_val[mem_latency-1];

  //==========================================================================
  // checks
  //==========================================================================

  // a response that is not taken stays put until it is
  assert property (@(posedge clk) disable iff (reset)
    (resp_val && !resp_rdy) |=> (resp_val && $stable(resp_msg)))
    else $error("test_mem: response changed while stalled");

endmodule

`default_nettype wire

/* hw/resp_queue.sv */
// response queue
// small registered circular buffer between the memory pipeline and the
// drop unit. no bypass, so a pushed entry is visible one cycle later.
// when full it still takes a push in a cycle that also pops.

`timescale 1ns/1ps
`default_nettype none

module resp_queue (
  input  logic                   clk,
  input  logic                   reset,

  input  mem_msg_pkg::mem_resp_t enq_msg,
  input  logic                   enq_val,
  output logic                   enq_rdy,

  output mem_msg_pkg::mem_resp_t deq_msg,
  output logic                   deq_val,
  input  logic                   deq_rdy
);

  import mem_cfg_pkg::*;
  import mem_msg_pkg::*;

  typedef logic [resp_queue_ptr_bits-1:0] ptr_t;
  typedef logic [resp_queue_cnt_bits-1:0] cnt_t;

  // entry storage, no reset
  mem_resp_t entries [resp_queue_depth];

  ptr_t wr_ptr;
  ptr_t rd_ptr;
  cnt_t count;

  logic full;
  logic push;
  logic pop;

  //==========================================================================
  // handshake
  //==========================================================================

  assign full    = (count == cnt_t'(resp_queue_depth));
  assign deq_val = (count != '0);
  assign deq_msg = entries[rd_ptr];

  // a pop in the same cycle makes room for a push when full
  assign enq_rdy = !full || deq_rdy;

  assign push = enq_val && enq_rdy;
  assign pop  = deq_val && deq_rdy;

  //==========================================================================
  // pointers and count
  //==========================================================================

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == ptr_t'(resp_queue_depth - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == ptr_t'(resp_queue_depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // count only moves when exactly one side fires
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      entries[wr_ptr] <= enq_msg;
    end
  end

  // occupancy never goes past the depth
  assert property (@(posedge clk) disable iff (reset)
    count <= cnt_t'(resp_queue_depth))
    else $error("resp_queue: count above depth");

endmodule

`default_nettype wire

/* hw/drop_unit.sv */
// drop unit
// removes the next response after a squash. a squash that meets a valid
// input drops it in the same cycle, otherwise the unit waits in the drop
// state and discards the next arriving response. repeated squashes before
// that response merge into one drop.

`timescale 1ns/1ps
`default_nettype none

module drop_unit (
  input  logic                   clk,
  input  logic                   reset,

  // squash pulse
  input  logic                   drop,

  input  mem_msg_pkg::mem_resp_t in_msg,
  input  logic                   in_val,
  output logic                   in_rdy,

  output mem_msg_pkg::mem_resp_t out_msg,
  output logic                   out_val,
  input  logic                   out_rdy
);

  import mem_cfg_pkg::*;

  drop_state_t state;
  drop_state_t next_state;
  logic        in_go;

  assign in_go   = in_val && in_rdy;

  // message goes straight through and only the valid is filtered
  assign out_msg = in_msg;

  //==========================================================================
  // FSM
  //==========================================================================

  always_comb begin
    if (state == state_pass) begin
      // only wait when the drop cannot be taken right now
      next_state = (drop && !in_go) ? state_drop : state_pass;
      // a squash hides a response that is already here
      out_val    = in_val && !drop;
      in_rdy     = out_rdy;
    end else begin
      // swallow whatever arrives next
      next_state = in_go ? state_pass : state_drop;
      out_val    = 1'b0;
      in_rdy     = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= state_pass;
    end else begin
      state <= next_state;
    end
  end

  // a squash that takes no input keeps the next response from leaving
  assert property (@(posedge clk) disable iff (reset)
    (drop && !in_go) |=> !out_val)
    else $error("drop_unit: response left after an untaken squash");

endmodule

`default_nettype wire

/* hw/mem_squash_top.sv */
// memory response path top
// chains the test memory, the response queue and the drop unit. requests
// go into the memory, responses come out of the drop unit with squashed
// ones removed.

`timescale 1ns/1ps
`default_nettype none

module mem_squash_top (
  input  logic                   clk,
  input  logic                   reset,

  // request port
  input  mem_msg_pkg::mem_type_t req_type,
  input  mem_msg_pkg::mem_tag_t  req_tag,
  input  mem_msg_pkg::mem_addr_t req_addr,
  input  mem_msg_pkg::mem_data_t req_data,
  input  logic                   req_val,
  output logic                   req_rdy,

  // squash from the core
  input  logic                   squash,

  // response port
  output mem_msg_pkg::mem_resp_t resp_msg,
  output logic                   resp_val,
  input  logic                   resp_rdy
);

  import mem_msg_pkg::*;

  // memory to queue
  mem_resp_t mem_resp_msg;
  logic      mem_resp_val;
  logic      mem_resp_rdy;

  // queue to drop unit
  mem_resp_t q_msg;
  logic      q_val;
  logic      q_rdy;

  test_mem i_test_mem (
    .clk      (clk),
    .reset    (reset),
    .req_type (req_type),
    .req_tag  (req_tag),
    .req_addr (req_addr),
    .req_data (req_data),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp_msg (mem_resp_msg),
    .resp_val (mem_resp_val),
    .resp_rdy (mem_resp_rdy)
  );

  resp_queue i_resp_queue (
    .clk     (clk),
    .reset   (reset),
    .enq_msg (mem_resp_msg),
    .enq_val (mem_resp_val),
    .enq_rdy (mem_resp_rdy),
    .deq_msg (q_msg),
    .deq_val (q_val),
    .deq_rdy (q_rdy)
  );

  drop_unit i_drop_unit (
    .clk     (clk),
    .reset   (reset),
    .drop    (squash),
    .in_msg  (q_msg),
    .in_val  (q_val),
    .in_rdy  (q_rdy),
    .out_msg (resp_msg),
    .out_val (resp_val),
    .out_rdy (resp_rdy)
  );

endmodule

`default_nettype wire

/* testbench/tb_mem_squash.sv */
// testbench for the memory response path
// reads operations and expected results from a data file, drives requests
// and squashes into the top level and checks every response that leaves
// the drop unit against a model queue of expected responses

`timescale 1ns/1ps
`default_nettype none

module tb_mem_squash;

  import mem_msg_pkg::*;

  // longest single wait in cycles
  localparam int wait_limit = 200;

  logic      clk;
  logic      reset;
  mem_type_t req_type;
  mem_tag_t  req_tag;
  mem_addr_t req_addr;
  mem_data_t req_data;
  logic      req_val;
  logic      req_rdy;
  logic      squash;
  mem_resp_t resp_msg;
  logic      resp_val;
  logic      resp_rdy;

  // expected responses in order
  // dropped reads are never pushed
  mem_resp_t exp_q [$];
  // file test number of each expected response
  int        exp_test_q [$];

  // holds resp_rdy low while set
  logic      hold_rdy;
  logic      timed_out;
  int        errors;
  int        checks;
  int        tests;

  mem_squash_top i_mem_squash_top (
    .clk      (clk),
    .reset    (reset),
    .req_type (req_type),
    .req_tag  (req_tag),
    .req_addr (req_addr),
    .req_data (req_data),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .squash   (squash),
    .resp_msg (resp_msg),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy)
  );

  // 4 ns clock
  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ==========================================================================
  // checking
  // ==========================================================================

  task automatic check(input string name, input mem_data_t got, input mem_data_t want);
    checks++;
    if (got !== want) begin
      errors++;
      $display("MISMATCH at %0t: %s got %0h expected %0h", $time, name, got, want);
    end
  endtask

  task automatic report_timeout(input string what);
    errors++;
    timed_out = 1'b1;
    $display("timeout after %0d cycles waiting for %s", wait_limit, what);
  endtask

  // compare one delivered response with the head of the model queue
  task automatic take_resp(input mem_resp_t msg);
    mem_resp_t want;
    int        test_id;
    int        err_before;
    err_before = errors;
    if (exp_q.size() == 0) begin
      errors++;
      $display("unexpected response at %0t with tag %0h, nothing was outstanding",
               $time, msg[mem_data_bits +: mem_tag_bits]);
    end else begin
      want    = exp_q.pop_front();
      test_id = exp_test_q.pop_front();
      check("resp_type", mem_data_t'(msg[mem_resp_bits-1]), mem_data_t'(want[mem_resp_bits-1]));
      check("resp_tag", mem_data_t'(msg[mem_data_bits +: mem_tag_bits]),
            mem_data_t'(want[mem_data_bits +: mem_tag_bits]));
      // only reads carry data worth checking
      if (want[mem_resp_bits-1] == mem_read) begin
        check("resp_data", msg[mem_data_bits-1:0], want[mem_data_bits-1:0]);
      end
      $display("test %0d %s tag %0h: %s", test_id,
               (want[mem_resp_bits-1] == mem_write) ? "write" : "read",
               want[mem_data_bits +: mem_tag_bits], (errors == err_before) ? "pass" : "fail");
    end
  endtask

  // response monitor with random back-pressure on about one cycle in four
  initial begin
    void'($urandom(71463));
    resp_rdy = 1'b0;
    forever begin
      @(posedge clk);
      if (!reset && resp_val && resp_rdy) begin
        take_resp(resp_msg);
      end
      resp_rdy <= hold_rdy ? 1'b0 : ($urandom % 4 != 0);
    end
  end

  // ==========================================================================
  // request side
  // ==========================================================================

  // drive one request at this rising edge, return at its accept edge
  task automatic send_req(input mem_type_t t, input mem_addr_t a, input mem_data_t d,
                          input mem_tag_t g, input mem_data_t rd_exp, input logic expect_resp);
    int n;
    n = 0;
    req_type <= t;
    req_addr <= a;
    req_data <= d;
    req_tag  <= g;
    req_val  <= 1'b1;
    @(negedge clk);
    while (!req_rdy && n < wait_limit) begin
      @(negedge clk);
      n++;
    end
    if (!req_rdy) begin
      report_timeout("req_rdy");
    end else if (expect_resp) begin
      exp_q.push_back({t, g, rd_exp});
      exp_test_q.push_back(tests);
    end
    @(posedge clk);
  endtask

  // wait until the model has no outstanding responses
  task automatic wait_drain();
    int n;
    n = 0;
    @(negedge clk);
    while (exp_q.size() != 0 && n < wait_limit) begin
      @(negedge clk);
      n++;
    end
    if (exp_q.size() != 0) begin
      report_timeout("outstanding responses");
    end
    @(posedge clk);
  endtask

  // squashed read followed by the given number of squash pulses one idle cycle apart
  task automatic squash_read(input mem_addr_t a, input mem_tag_t g, input int pulses);
    req_val <= 1'b0;
    // drained first, so this read is the only outstanding response
    wait_drain();
    if (!timed_out) begin
      send_req(mem_read, a, '0, g, '0, 1'b0);
      req_val <= 1'b0;
      for (int i = 0; i < pulses; i++) begin
        squash <= 1'b1;
        @(posedge clk);
        squash <= 1'b0;
        @(posedge clk);
      end
      $display("test %0d read_squash tag %0h: squashed with %0d pulse(s)", tests, g, pulses);
    end
  endtask

  // writes with resp_rdy held low until req_rdy falls, then release
  task automatic stall_run(input mem_addr_t a, input mem_data_t d, input mem_tag_t g);
    int       n;
    mem_tag_t t;
    n = 0;
    t = g;
    req_val <= 1'b0;
    @(negedge clk);
    hold_rdy = 1'b1;
    @(posedge clk);
    req_type <= mem_write;
    req_addr <= a;
    req_data <= d;
    req_tag  <= t;
    req_val  <= 1'b1;
    @(negedge clk);
    while (req_rdy && n < wait_limit) begin
      exp_q.push_back({mem_write, t, d});
      exp_test_q.push_back(tests);
      @(posedge clk);
      t++;
      req_tag <= t;
      @(negedge clk);
      n++;
    end
    @(posedge clk);
    req_val <= 1'b0;
    if (req_rdy) begin
      report_timeout("req_rdy to fall under a stall");
    end
    @(negedge clk);
    hold_rdy = 1'b0;
    wait_drain();
    $display("test %0d stall: %0d writes accepted before req_rdy fell", tests, n);
  endtask

  // ==========================================================================
  // main sequence
  // ==========================================================================

  initial begin
    int              fd;
    int              n;
    string           line;
    logic [8*16-1:0] cmd;
    logic [31:0]     addr;
    logic [31:0]     data;
    logic [31:0]     tag;
    logic [31:0]     expd;
    reset     = 1'b1;
    req_type  = mem_read;
    req_tag   = '0;
    req_addr  = '0;
    req_data  = '0;
    req_val   = 1'b0;
    squash    = 1'b0;
    hold_rdy  = 1'b0;
    timed_out = 1'b0;
    errors    = 0;
    checks    = 0;
    tests     = 0;
    repeat (8) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);

    fd = $fopen("testbench/mem_squash_tests.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("could not open testbench/mem_squash_tests.txt");
    end
    while (fd != 0 && !$feof(fd) && !timed_out) begin
      line = "";
      void'($fgets(line, fd));
      // skip blank and comment lines
      if (line.len() < 2 || line[0] == "#") begin
        continue;
      end
      n = $sscanf(line, "%s %h %h %h %h", cmd, addr, data, tag, expd);
      if (n != 5) begin
        errors++;
        $display("malformed line in test file: %s", line);
        continue;
      end
      tests++;
      if (cmd == "write") begin
        send_req(mem_write, mem_addr_t'(addr), data, mem_tag_t'(tag), '0, 1'b1);
      end else if (cmd == "read") begin
        send_req(mem_read, mem_addr_t'(addr), '0, mem_tag_t'(tag), expd, 1'b1);
      end else if (cmd == "read_squash") begin
        squash_read(mem_addr_t'(addr), mem_tag_t'(tag), int'(data));
      end else if (cmd == "stall") begin
        stall_run(mem_addr_t'(addr), data, mem_tag_t'(tag));
      end else begin
        errors++;
        $display("unknown command in test file: %s", line);
      end
    end
    req_val <= 1'b0;
    if (fd != 0) begin
      $fclose(fd);
    end
    if (!timed_out) begin
      wait_drain();
    end
    // idle time so a stray or duplicate response still shows up
    repeat (10) @(posedge clk);

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* testbench/mem_squash_tests.txt */
# command  addr(hex) data(hex) tag(hex) expected read data(hex)
# read_squash takes the number of squash pulses in the data column
write        05  11112222  1  00000000
read         05  00000000  2  11112222
write        06  aaaa0006  3  00000000
write        07  bbbb0007  4  00000000
read         06  00000000  5  aaaa0006
read         07  00000000  6  bbbb0007
write        05  33334444  7  00000000
read         05  00000000  8  33334444
read_squash  06  00000001  9  00000000
read         07  00000000  a  bbbb0007
read_squash  05  00000002  b  00000000
read         05  00000000  c  33334444
stall        20  5a5a5a5a  0  00000000
read         20  00000000  d  5a5a5a5a
write        3f  0f0f0f0f  e  00000000
write        00  f0f0f0f0  f  00000000
read         3f  00000000  1  0f0f0f0f
read         00  00000000  2  f0f0f0f0
write        06  cafe0006  3  00000000
read         06  00000000  4  cafe0006
read_squash  3f  00000001  5  00000000
write        07  0d0d0d0d  6  00000000
read         07  00000000  7  0d0d0d0d

/* all.f */
hw/mem_cfg_pkg.sv
hw/mem_msg_pkg.sv
hw/test_mem.sv
hw/resp_queue.sv
hw/drop_unit.sv
hw/mem_squash_top.sv
testbench/tb_mem_squash.sv

/* run.sh */
#!/bin/sh
# build the testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal -f all.f \
  --top-module tb_mem_squash -o sim_tb \
  && ./obj_dir/sim_tb > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }

cat sim.log
grep -q '>>> FAIL' sim.log && { echo "simulation reported failure"; exit 1; }
grep -q '>>> PASS' sim.log || { echo "no pass message in log"; exit 1; }
exit 0
